//--- Bender.yml
package:
  name: tage_bpu

sources:
  # Design, in compile order
  - hdl/tage_pkg.sv
  - hdl/predictor_table.sv
  - hdl/history_hash.sv
  - hdl/tagged_component.sv
  - hdl/tage_update_policy.sv
  - hdl/tage_predictor.sv
  # Testbench
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_tage_predictor.sv

//--- hdl/history_hash.sv
// Folded global history hash into a tagged table index and tag

`timescale 1ns/1ps

module history_hash #(
    parameter int HIST_LEN = 5
) (
    input  logic [tage_pkg::PC_WIDTH-1:0]  pc_i,
    input  logic [tage_pkg::GHR_LEN-1:0]   ghr_i,
    output logic [tage_pkg::TAG_IDX_W-1:0] idx_o,
    output logic [tage_pkg::TAG_W-1:0]     tag_o
);

    // PC field positions, word aligned
    localparam int IDX_LSB = 2;
    localparam int TAG_LSB = IDX_LSB + tage_pkg::TAG_IDX_W;

    logic [tage_pkg::TAG_IDX_W-1:0] idx_fold;
    logic [tage_pkg::TAG_W-1:0]     tag_fold;

    // Newest history sits at bit 0
    // Bit i lands in chunk position i mod W, which is the same as XOR of
    // consecutive W-bit chunks with the last one zero-padded
    always_comb begin
        idx_fold = '0;
        tag_fold = '0;
        for (int i = 0; i < HIST_LEN; i++) begin
            idx_fold[i % tage_pkg::TAG_IDX_W] ^= ghr_i[i];
            tag_fold[i % tage_pkg::TAG_W]     ^= ghr_i[i];
        end
    end

    // Index from low PC bits, tag from the bits just above
    assign idx_o = pc_i[IDX_LSB +: tage_pkg::TAG_IDX_W] ^ idx_fold;
    assign tag_o = pc_i[TAG_LSB +: tage_pkg::TAG_W] ^ tag_fold;

endmodule

//--- hdl/predictor_table.sv
// Flop-array predictor table with a payload type parameter
// Two combinational read ports and one clocked write port

`timescale 1ns/1ps

module predictor_table #(
    parameter int  IDX_W   = 6,
    parameter type entry_t = logic [7:0]
) (
    input  logic             clk,
    input  logic             rst_n,

    // Prediction read port
    input  logic [IDX_W-1:0] pred_idx_i,
    output entry_t           pred_entry_o,

    // Update read port
    input  logic [IDX_W-1:0] upd_idx_i,
    output entry_t           upd_entry_o,

    // Write port
    input  logic             wr_en_i,
    input  logic [IDX_W-1:0] wr_idx_i,
    input  entry_t           wr_entry_i
);

    localparam int DEPTH = 1 << IDX_W;

    entry_t mem_q [DEPTH];

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    // All entries cleared so tagged valid bits start low
    // and base counters start at strongly not taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            mem_q[wr_idx_i] <= wr_entry_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////

    // Reads see the contents before this edge's write
    assign pred_entry_o = mem_q[pred_idx_i];
    assign upd_entry_o  = mem_q[upd_idx_i];

endmodule

//--- hdl/tage_pkg.sv
// Shared widths, table entry types, prediction metadata and update record
// for the TAGE direction predictor

package tage_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int PC_WIDTH   = 32;
    // Base table, direct mapped on the PC
    localparam int BASE_IDX_W = 8;
    // Tagged tables, PC hashed with folded history
    localparam int TAG_IDX_W  = 6;
    localparam int TAG_W      = 8;
    // Counters, MSB set means taken
    localparam int BASE_CTR_W = 2;
    localparam int TAG_CTR_W  = 3;
    localparam int USEFUL_W   = 2;
    localparam int NUM_TAGGED = 2;
    localparam int GHR_LEN    = 16;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    // 0 is the base table, 1 and up are tagged components by history length
    typedef logic [1:0] provider_id_t;

    typedef struct packed {
        logic [BASE_CTR_W-1:0] ctr;
    } base_entry_t;

    typedef struct packed {
        logic                  valid;
        logic [TAG_W-1:0]      tag;
        logic [TAG_CTR_W-1:0]  ctr;
        logic [USEFUL_W-1:0]   useful;
    } tagged_entry_t;

    // Returned by the front end with the outcome
    // Element c of tag_idx and tag belongs to component c+1
    typedef struct packed {
        provider_id_t                          provider;
        logic                                  alt_taken;
        logic                                  pred_taken;
        logic [BASE_IDX_W-1:0]                 base_idx;
        logic [NUM_TAGGED-1:0][TAG_IDX_W-1:0]  tag_idx;
        logic [NUM_TAGGED-1:0][TAG_W-1:0]      tag;
    } bpu_meta_t;

    typedef struct packed {
        logic      valid;
        logic      is_conditional;
        logic      taken;
        bpu_meta_t meta;
    } bpu_update_t;

endpackage

//--- hdl/tage_predictor.sv
// TAGE predictor top: global history, base table, tagged components,
// provider selection, update policy and the prediction output register

`timescale 1ns/1ps

module tage_predictor #(
    parameter int HIST_LEN_1 = 5,
    parameter int HIST_LEN_2 = 15
) (
    input  logic                          clk,
    input  logic                          rst_n,

    // Prediction request
    input  logic                          predict_req_i,
    input  logic [tage_pkg::PC_WIDTH-1:0] pc_i,

    // Outcome with metadata handed back
    input  tage_pkg::bpu_update_t         update_i,

    // Prediction, one cycle after the request
    output logic                          predict_valid_o,
    output logic                          predict_taken_o,
    output tage_pkg::bpu_meta_t           meta_o
);

    localparam int NT = tage_pkg::NUM_TAGGED;

    logic [tage_pkg::GHR_LEN-1:0]             ghr_q;
    logic                                     history_shift;
    logic                                     shift_bit;

    logic [tage_pkg::BASE_IDX_W-1:0]          base_pred_idx;
    tage_pkg::base_entry_t                    base_pred_entry;
    tage_pkg::base_entry_t                    base_upd_entry;
    logic                                     base_wr_en;
    tage_pkg::base_entry_t                    base_wr;

    logic [NT-1:0]                            tag_hit;
    logic [NT-1:0][tage_pkg::TAG_CTR_W-1:0]   tag_ctr;
    logic [NT-1:0][tage_pkg::TAG_IDX_W-1:0]   tag_idx;
    logic [NT-1:0][tage_pkg::TAG_W-1:0]       tag_val;
    tage_pkg::tagged_entry_t [NT-1:0]         tag_upd_entry;
    logic [NT-1:0]                            tag_wr_en;
    tage_pkg::tagged_entry_t [NT-1:0]         tag_wr;

    logic [NT:0]                              comp_taken;
    tage_pkg::provider_id_t                   provider;
    tage_pkg::provider_id_t                   alt;
    tage_pkg::bpu_meta_t                      meta_d;
    tage_pkg::bpu_meta_t                      meta_q;

    ////////////////////////////////////////////////////////////
    // Global history
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ghr_q <= '0;
        end else if (history_shift) begin
            // Newest outcome enters at bit 0
            ghr_q <= {ghr_q[tage_pkg::GHR_LEN-2:0], shift_bit};
        end
    end

    ////////////////////////////////////////////////////////////
    // Tables
    ////////////////////////////////////////////////////////////

    // Base table indexed by the word address
    assign base_pred_idx = pc_i[2 +: tage_pkg::BASE_IDX_W];

    predictor_table #(
        .IDX_W   (tage_pkg::BASE_IDX_W),
        .entry_t (tage_pkg::base_entry_t)
    ) base_table_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .pred_idx_i   (base_pred_idx),
        .pred_entry_o (base_pred_entry),
        .upd_idx_i    (update_i.meta.base_idx),
        .upd_entry_o  (base_upd_entry),
        .wr_en_i      (base_wr_en),
        .wr_idx_i     (update_i.meta.base_idx),
        .wr_entry_i   (base_wr)
    );

    // Component c+1, shorter history first
    for (genvar c = 0; c < NT; c++) begin : g_tagged
        tagged_component #(
            .HIST_LEN ((c == 0) ? HIST_LEN_1 : HIST_LEN_2)
        ) tagged_component_inst (
            .clk         (clk),
            .rst_n       (rst_n),
            .pc_i        (pc_i),
            .ghr_i       (ghr_q),
            .hit_o       (tag_hit[c]),
            .ctr_o       (tag_ctr[c]),
            .idx_o       (tag_idx[c]),
            .tag_o       (tag_val[c]),
            .upd_idx_i   (update_i.meta.tag_idx[c]),
            .upd_entry_o (tag_upd_entry[c]),
            .wr_en_i     (tag_wr_en[c]),
            .wr_idx_i    (update_i.meta.tag_idx[c]),
            .wr_entry_i  (tag_wr[c])
        );
        assign comp_taken[c+1] = tag_ctr[c][tage_pkg::TAG_CTR_W-1];
    end

    assign comp_taken[0] = base_pred_entry.ctr[tage_pkg::BASE_CTR_W-1];

    ////////////////////////////////////////////////////////////
    // Provider and alternate selection
    ////////////////////////////////////////////////////////////

    // Longest hit provides, the previous longest hit is the alternate
    always_comb begin
        provider = '0;
        alt      = '0;
        for (int c = 0; c < NT; c++) begin
            if (tag_hit[c]) begin
                alt      = provider;
                provider = tage_pkg::provider_id_t'(c + 1);
            end
        end
    end

    always_comb begin
        meta_d            = '0;
        meta_d.provider   = provider;
        meta_d.alt_taken  = comp_taken[alt];
        meta_d.pred_taken = comp_taken[provider];
        meta_d.base_idx   = base_pred_idx;
        meta_d.tag_idx    = tag_idx;
        meta_d.tag        = tag_val;
    end

    ////////////////////////////////////////////////////////////
    // Update
    ////////////////////////////////////////////////////////////

    tage_update_policy tage_update_policy_inst (
        .update_i        (update_i),
        .base_rd_i       (base_upd_entry),
        .tag_rd_i        (tag_upd_entry),
        .base_wr_en_o    (base_wr_en),
        .base_wr_o       (base_wr),
        .tag_wr_en_o     (tag_wr_en),
        .tag_wr_o        (tag_wr),
        .history_shift_o (history_shift),
        .shift_bit_o     (shift_bit)
    );

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            predict_valid_o <= 1'b0;
        end else begin
            predict_valid_o <= predict_req_i;
        end
    end

    // Payload only loads on a request
    always_ff @(posedge clk) begin
        if (predict_req_i) begin
            meta_q <= meta_d;
        end
    end

    assign predict_taken_o = meta_q.pred_taken;
    assign meta_o          = meta_q;

endmodule

//--- hdl/tage_update_policy.sv
// TAGE update policy: counter training, useful adjustment,
// allocation on misprediction, useful aging and history shift

`timescale 1ns/1ps

module tage_update_policy (
    input  tage_pkg::bpu_update_t                            update_i,

    // Entries read at the stored indices
    input  tage_pkg::base_entry_t                            base_rd_i,
    input  tage_pkg::tagged_entry_t [tage_pkg::NUM_TAGGED-1:0] tag_rd_i,

    // One write per table
    output logic                                             base_wr_en_o,
    output tage_pkg::base_entry_t                            base_wr_o,
    output logic [tage_pkg::NUM_TAGGED-1:0]                  tag_wr_en_o,
    output tage_pkg::tagged_entry_t [tage_pkg::NUM_TAGGED-1:0] tag_wr_o,

    // Global history control
    output logic                                             history_shift_o,
    output logic                                             shift_bit_o
);

    // Weak initial counters for a fresh allocation
    localparam logic [tage_pkg::TAG_CTR_W-1:0] WEAK_TAKEN =
        1 << (tage_pkg::TAG_CTR_W - 1);
    localparam logic [tage_pkg::TAG_CTR_W-1:0] WEAK_NOT_TAKEN = WEAK_TAKEN - 1'b1;

    logic                   upd_active;
    logic                   mispredict;
    logic                   alloc_found;
    tage_pkg::provider_id_t provider;

    assign upd_active = update_i.valid && update_i.is_conditional;
    assign mispredict = update_i.meta.pred_taken != update_i.taken;
    assign provider   = update_i.meta.provider;

    ////////////////////////////////////////////////////////////
    // Table writes
    ////////////////////////////////////////////////////////////

    always_comb begin
        // Default to rewriting what was read, enables low
        base_wr_en_o = 1'b0;
        base_wr_o    = base_rd_i;
        tag_wr_en_o  = '0;
        tag_wr_o     = tag_rd_i;
        alloc_found  = 1'b0;

        if (upd_active) begin
            // Provider counter training
            if (provider == '0) begin
                base_wr_en_o = 1'b1;
                if (update_i.taken) begin
                    if (base_rd_i.ctr != '1) begin
                        base_wr_o.ctr = base_rd_i.ctr + 1'b1;
                    end
                end else if (base_rd_i.ctr != '0) begin
                    base_wr_o.ctr = base_rd_i.ctr - 1'b1;
                end
            end

            for (int c = 0; c < tage_pkg::NUM_TAGGED; c++) begin
                if (provider == tage_pkg::provider_id_t'(c + 1)) begin
                    tag_wr_en_o[c] = 1'b1;
                    if (update_i.taken) begin
                        if (tag_rd_i[c].ctr != '1) begin
                            tag_wr_o[c].ctr = tag_rd_i[c].ctr + 1'b1;
                        end
                    end else if (tag_rd_i[c].ctr != '0) begin
                        tag_wr_o[c].ctr = tag_rd_i[c].ctr - 1'b1;
                    end
                    // Useful only moves when alternate disagreed
                    if (update_i.meta.pred_taken != update_i.meta.alt_taken) begin
                        if (!mispredict) begin
                            if (tag_rd_i[c].useful != '1) begin
                                tag_wr_o[c].useful = tag_rd_i[c].useful + 1'b1;
                            end
                        end else if (tag_rd_i[c].useful != '0) begin
                            tag_wr_o[c].useful = tag_rd_i[c].useful - 1'b1;
                        end
                    end
                end
            end

            // Allocation in the lowest longer component with useful zero
            if (mispredict) begin
                for (int c = 0; c < tage_pkg::NUM_TAGGED; c++) begin
                    if (tage_pkg::provider_id_t'(c + 1) > provider && !alloc_found &&
                        tag_rd_i[c].useful == '0) begin
                        alloc_found         = 1'b1;
                        tag_wr_en_o[c]      = 1'b1;
                        tag_wr_o[c].valid   = 1'b1;
                        tag_wr_o[c].tag     = update_i.meta.tag[c];
                        tag_wr_o[c].useful  = '0;
                        tag_wr_o[c].ctr     = update_i.taken ? WEAK_TAKEN : WEAK_NOT_TAKEN;
                    end
                end
                // Nothing free, so age every longer component
                if (!alloc_found) begin
                    for (int c = 0; c < tage_pkg::NUM_TAGGED; c++) begin
                        if (tage_pkg::provider_id_t'(c + 1) > provider) begin
                            tag_wr_en_o[c] = 1'b1;
                            if (tag_rd_i[c].useful != '0) begin
                                tag_wr_o[c].useful = tag_rd_i[c].useful - 1'b1;
                            end
                        end
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // History
    ////////////////////////////////////////////////////////////

    // Only conditional outcomes enter the history
    assign history_shift_o = upd_active;
    assign shift_bit_o     = update_i.taken;

endmodule

//--- hdl/tagged_component.sv
// One tagged TAGE component with its hash, its table and the hit check

`timescale 1ns/1ps

module tagged_component #(
    parameter int HIST_LEN = 5
) (
    input  logic                            clk,
    input  logic                            rst_n,

    // Prediction side
    input  logic [tage_pkg::PC_WIDTH-1:0]   pc_i,
    input  logic [tage_pkg::GHR_LEN-1:0]    ghr_i,
    output logic                            hit_o,
    output logic [tage_pkg::TAG_CTR_W-1:0]  ctr_o,
    output logic [tage_pkg::TAG_IDX_W-1:0]  idx_o,
    output logic [tage_pkg::TAG_W-1:0]      tag_o,

    // Update side, toward the policy
    input  logic [tage_pkg::TAG_IDX_W-1:0]  upd_idx_i,
    output tage_pkg::tagged_entry_t         upd_entry_o,
    input  logic                            wr_en_i,
    input  logic [tage_pkg::TAG_IDX_W-1:0]  wr_idx_i,
    input  tage_pkg::tagged_entry_t         wr_entry_i
);

    tage_pkg::tagged_entry_t pred_entry;

    // Index and tag for this history length
    history_hash #(
        .HIST_LEN (HIST_LEN)
    ) history_hash_inst (
        .pc_i  (pc_i),
        .ghr_i (ghr_i),
        .idx_o (idx_o),
        .tag_o (tag_o)
    );

    predictor_table #(
        .IDX_W   (tage_pkg::TAG_IDX_W),
        .entry_t (tage_pkg::tagged_entry_t)
    ) table_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .pred_idx_i   (idx_o),
        .pred_entry_o (pred_entry),
        .upd_idx_i    (upd_idx_i),
        .upd_entry_o  (upd_entry_o),
        .wr_en_i      (wr_en_i),
        .wr_idx_i     (wr_idx_i),
        .wr_entry_i   (wr_entry_i)
    );

    // Hit needs a valid entry and a matching tag
    assign hit_o = pred_entry.valid && (pred_entry.tag == tag_o);
    assign ctr_o = pred_entry.ctr;

endmodule

//--- tage_bpu.f
+incdir+include
hdl/tage_pkg.sv
hdl/predictor_table.sv
hdl/history_hash.sv
hdl/tagged_component.sv
hdl/tage_update_policy.sv
hdl/tage_predictor.sv
verification/tb_clock_gen.sv
verification/tb_tage_predictor.sv

//--- verification/tb_clock_gen.sv
// Testbench clock and reset generator, 20 ns period, 8-cycle reset

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

//--- include/tage_tb_checks.svh
// Compare tasks for taken, valid, provider and metadata results
// Check and test counters with the per-test summary line

`ifndef TAGE_TB_CHECKS_SVH
`define TAGE_TB_CHECKS_SVH

int checks_run    = 0;
int checks_failed = 0;
int tests_run     = 0;
int tests_failed  = 0;

task automatic check_taken(input string name, input logic exp, input logic act);
    checks_run++;
    if (exp !== act) begin
        checks_failed++;
        $display("error %s: taken expected %0b actual %0b", name, exp, act);
    end
endtask

task automatic check_valid(input string name, input logic exp, input logic act);
    checks_run++;
    if (exp !== act) begin
        checks_failed++;
        $display("error %s: valid expected %0b actual %0b", name, exp, act);
    end
endtask

task automatic check_provider(input string name, input tage_pkg::provider_id_t exp,
                              input tage_pkg::provider_id_t act);
    checks_run++;
    if (exp !== act) begin
        checks_failed++;
        $display("error %s: provider expected %0d actual %0d", name, exp, act);
    end
endtask

// Whole record compared and printed as one hex word
task automatic check_meta(input string name, input tage_pkg::bpu_meta_t exp,
                          input tage_pkg::bpu_meta_t act);
    checks_run++;
    if (exp !== act) begin
        checks_failed++;
        $display("error %s: meta expected %h actual %h", name, exp, act);
    end
endtask

// One line per finished test
task automatic close_test(input string name, input int errors_before);
    tests_run++;
    if (checks_failed != errors_before) begin
        tests_failed++;
        $display("test %s: %0d errors", name, checks_failed - errors_before);
    end else begin
        $display("test %s: ok", name);
    end
endtask

`endif

//--- verification/tb_tage_predictor.sv
// TAGE predictor testbench with a reference model and directed and random scenarios
// Stimulus driven 2 ns after the rising edge

`timescale 1ns/1ps

module tb_tage_predictor;

    localparam int TIMEOUT_CYCLES = 10;

    logic                  clk;
    logic                  rst_n;
    logic                  predict_req;
    logic [31:0]           pc;
    tage_pkg::bpu_update_t upd;
    logic                  predict_valid;
    logic                  predict_taken;
    tage_pkg::bpu_meta_t   meta;

    integer seed = 32'h70d6_d95d;

    // Reference model state
    logic [15:0]             m_ghr;
    logic [1:0]              m_base [256];
    tage_pkg::tagged_entry_t m_tag [2][64];
    int                      aging_events;

    `include "tage_tb_checks.svh"

    tb_clock_gen tb_clock_gen_inst (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    tage_predictor #(
        .HIST_LEN_1 (5),
        .HIST_LEN_2 (15)
    ) tage_predictor_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .predict_req_i   (predict_req),
        .pc_i            (pc),
        .update_i        (upd),
        .predict_valid_o (predict_valid),
        .predict_taken_o (predict_taken),
        .meta_o          (meta)
    );

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // XOR of W-bit chunks of the newest len bits
    function automatic logic [7:0] fold_hist(input logic [15:0] h, input int len, input int w);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < len; i++) begin
            r[i % w] ^= h[i];
        end
        return r;
    endfunction

    function automatic tage_pkg::bpu_meta_t model_predict(input logic [31:0] pc_v);
        tage_pkg::bpu_meta_t m;
        logic [2:0]          comp_tk;
        logic [7:0]          idx_fold;
        logic [5:0]          idx;
        logic [7:0]          tg;
        int                  len;
        int                  prov;
        int                  alt;
        m          = '0;
        prov       = 0;
        alt        = 0;
        m.base_idx = pc_v[9:2];
        comp_tk[0] = m_base[m.base_idx][1];
        for (int c = 0; c < 2; c++) begin
            len      = (c == 0) ? 5 : 15;
            idx_fold = fold_hist(m_ghr, len, 6);
            idx      = pc_v[7:2] ^ idx_fold[5:0];
            tg       = pc_v[15:8] ^ fold_hist(m_ghr, len, 8);
            m.tag_idx[c]   = idx;
            m.tag[c]       = tg;
            comp_tk[c + 1] = m_tag[c][idx].ctr[2];
            if (m_tag[c][idx].valid && m_tag[c][idx].tag == tg) begin
                alt  = prov;
                prov = c + 1;
            end
        end
        m.provider   = tage_pkg::provider_id_t'(prov);
        m.pred_taken = comp_tk[prov];
        m.alt_taken  = comp_tk[alt];
        return m;
    endfunction

    function automatic void model_update(input tage_pkg::bpu_update_t u);
        tage_pkg::tagged_entry_t e;
        int                      p;
        logic                    wrong;
        logic                    found;
        if (!(u.valid && u.is_conditional)) begin
            return;
        end
        p     = u.meta.provider;
        wrong = u.meta.pred_taken != u.taken;
        // Provider training
        if (p == 0) begin
            if (u.taken && m_base[u.meta.base_idx] != 2'd3) begin
                m_base[u.meta.base_idx]++;
            end else if (!u.taken && m_base[u.meta.base_idx] != 2'd0) begin
                m_base[u.meta.base_idx]--;
            end
        end else begin
            e = m_tag[p-1][u.meta.tag_idx[p-1]];
            if (u.taken && e.ctr != 3'd7) begin
                e.ctr++;
            end else if (!u.taken && e.ctr != 3'd0) begin
                e.ctr--;
            end
            if (u.meta.pred_taken != u.meta.alt_taken) begin
                if (!wrong && e.useful != 2'd3) begin
                    e.useful++;
                end else if (wrong && e.useful != 2'd0) begin
                    e.useful--;
                end
            end
            m_tag[p-1][u.meta.tag_idx[p-1]] = e;
        end
        // Allocate above the provider or age when all are busy
        if (wrong && p < 2) begin
            found = 1'b0;
            for (int j = p; j < 2; j++) begin
                if (!found && m_tag[j][u.meta.tag_idx[j]].useful == 2'd0) begin
                    found = 1'b1;
                    e.valid  = 1'b1;
                    e.tag    = u.meta.tag[j];
                    e.useful = 2'd0;
                    e.ctr    = u.taken ? 3'd4 : 3'd3;
                    m_tag[j][u.meta.tag_idx[j]] = e;
                end
            end
            if (!found) begin
                aging_events++;
                for (int j = p; j < 2; j++) begin
                    if (m_tag[j][u.meta.tag_idx[j]].useful != 2'd0) begin
                        m_tag[j][u.meta.tag_idx[j]].useful--;
                    end
                end
            end
        end
        m_ghr = {m_ghr[14:0], u.taken};
    endfunction

    ////////////////////////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////////////////////////

    // Entered and left 2 ns after a rising edge
    task automatic do_predict(input string name, input logic [31:0] pc_v,
                              output tage_pkg::bpu_meta_t got);
        tage_pkg::bpu_meta_t exp;
        int                  waited;
        exp         = model_predict(pc_v);
        predict_req = 1'b1;
        pc          = pc_v;
        @(posedge clk);
        #2;
        predict_req = 1'b0;
        waited      = 0;
        while (!predict_valid) begin
            if (waited >= TIMEOUT_CYCLES) begin
                $display("timeout: no prediction came back in test %s", name);
                $display(">>> FAIL");
                $finish;
            end
            @(posedge clk);
            #2;
            waited++;
        end
        check_taken(name, exp.pred_taken, predict_taken);
        check_meta(name, exp, meta);
        got = exp;
    endtask

    task automatic send_update(input tage_pkg::bpu_meta_t m, input logic taken,
                               input logic cond);
        tage_pkg::bpu_update_t u;
        u.valid          = 1'b1;
        u.is_conditional = cond;
        u.taken          = taken;
        u.meta           = m;
        upd              = u;
        @(posedge clk);
        #2;
        upd = '0;
        model_update(u);
    endtask

    ////////////////////////////////////////////////////////////
    // Scenarios
    ////////////////////////////////////////////////////////////

    initial begin
        tage_pkg::bpu_meta_t m;
        tage_pkg::bpu_meta_t first;
        logic [31:0]         pool [8];
        logic [3:0]          bias;
        int                  errs;
        int                  waited;
        int                  k;
        int                  start_aging;
        logic                tk;

        predict_req  = 1'b0;
        pc           = '0;
        upd          = '0;
        m_ghr        = '0;
        aging_events = 0;
        bias         = 4'b1101;
        for (int i = 0; i < 256; i++) begin
            m_base[i] = '0;
        end
        for (int c = 0; c < 2; c++) begin
            for (int i = 0; i < 64; i++) begin
                m_tag[c][i] = '0;
            end
        end
        for (int i = 0; i < 8; i++) begin
            pool[i] = 32'h0000_4000 + (i * 32'h0000_0104);
        end

        waited = 0;
        while (rst_n !== 1'b1) begin
            if (waited >= 20) begin
                $display("timeout: reset never released");
                $display(">>> FAIL");
                $finish;
            end
            @(posedge clk);
            waited++;
        end
        @(posedge clk);
        #2;

        // Idle cycles after reset then cold predictions
        errs = checks_failed;
        repeat (5) begin
            check_valid("reset_state", 1'b0, predict_valid);
            @(posedge clk);
            #2;
        end
        for (int i = 0; i < 4; i++) begin
            do_predict("reset_state", pool[i], m);
            check_taken("reset_state", 1'b0, predict_taken);
            check_provider("reset_state", 2'd0, meta.provider);
        end
        close_test("reset_state", errs);

        // Base counter up past 2 and back down
        errs = checks_failed;
        repeat (4) begin
            do_predict("base_training", 32'h0000_1040, m);
            send_update(m, 1'b1, 1'b1);
        end
        do_predict("base_training", 32'h0000_1040, m);
        check_provider("base_training", 2'd0, meta.provider);
        check_taken("base_training", 1'b1, predict_taken);
        send_update(m, 1'b0, 1'b1);
        repeat (3) begin
            do_predict("base_training", 32'h0000_1040, m);
            send_update(m, 1'b0, 1'b1);
        end
        do_predict("base_training", 32'h0000_1040, m);
        check_provider("base_training", 2'd0, meta.provider);
        check_taken("base_training", 1'b0, predict_taken);
        close_test("base_training", errs);

        // All-taken history stays fixed so the next lookup hits the new entry
        errs = checks_failed;
        repeat (16) begin
            do_predict("allocation", 32'h0000_2080, m);
            send_update(m, 1'b1, 1'b1);
        end
        do_predict("allocation", 32'h0000_3104, m);
        send_update(m, 1'b1, 1'b1);
        do_predict("allocation", 32'h0000_3104, m);
        check_taken("allocation", 1'b1, predict_taken);
        check_provider("allocation", 2'd1, meta.provider);
        send_update(m, 1'b1, 1'b1);
        close_test("allocation", errs);

        // Biased outcomes until a misprediction finds no free entry
        errs        = checks_failed;
        start_aging = aging_events;
        k           = 0;
        while (aging_events == start_aging && k < 3000) begin
            do_predict("useful_aging", pool[k % 4], m);
            tk = (($random(seed) & 32'hf) < 13) ? bias[k % 4] : !bias[k % 4];
            send_update(m, tk, 1'b1);
            k++;
        end
        if (aging_events == start_aging) begin
            checks_failed++;
            $display("no useful aging event was reached within the step limit");
        end
        do_predict("useful_aging", pool[k % 4], m);
        close_test("useful_aging", errs);

        // Unconditional updates leave state untouched
        errs = checks_failed;
        for (int i = 0; i < 5; i++) begin
            do_predict("unconditional", pool[i], first);
            send_update(first, ($random(seed) & 1) != 0, 1'b0);
            do_predict("unconditional", pool[i], m);
            check_meta("unconditional", first, meta);
        end
        close_test("unconditional", errs);

        // Random mix with mostly conditional updates
        errs = checks_failed;
        for (int i = 0; i < 300; i++) begin
            do_predict("random_mix", pool[$unsigned($random(seed)) % 8], m);
            send_update(m, ($random(seed) & 1) != 0, ($random(seed) & 7) != 0);
        end
        close_test("random_mix", errs);

        $display("tests %0d, failed %0d, checks %0d, check errors %0d",
                 tests_run, tests_failed, checks_run, checks_failed);
        if (checks_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
